//--- design/eeprom_store.sv
`include "joybus_defines.svh"

module eeprom_store (
    input  logic                             clk,
    input  joybus_pkg::eeprom_wr_t           eeprom_wr,
    input  logic [`JOYBUS_EEPROM_ADDR_W-1:0] raddr,
    output logic [7:0]                       rdata
);

    logic [7:0] mem [0:(1 << `JOYBUS_EEPROM_ADDR_W) - 1];

    always_ff @(posedge clk) begin
        if (eeprom_wr.write) begin
            mem[eeprom_wr.address] <= eeprom_wr.wdata;
        end
    end

    // Read is combinational so the reply mux sees data in the same cycle
    always_comb begin
        rdata = mem[raddr];
    end

endmodule

//--- design/joybus_cmd.sv
`include "joybus_defines.svh"

module joybus_cmd (
    input  logic                   clk,
    input  logic                   reset,
    input  joybus_pkg::rx_event_t  rx_event,
    input  logic                   eeprom_enabled,
    input  logic                   byte_taken,
    output logic                   tx_start,
    output joybus_pkg::cmd_ctx_t   ctx,
    output joybus_pkg::eeprom_wr_t eeprom_wr
);

    import joybus_pkg::*;

    rx_state_e                                          rx_state;
    cmd_e                                               cmd;
    logic [3:0]                                         byte_count;
    logic [`JOYBUS_EEPROM_ADDR_W-`JOYBUS_SUBADDR_W-1:0] block;
    logic [`JOYBUS_SUBADDR_W-1:0]                       subaddr;
    rtc_regs_t                                          rtc;
    logic                                               supported;
    logic                                               data_valid;

    always_comb begin
        case (rx_event.byte_data)
            EEPROM_STATUS, EEPROM_READ, EEPROM_WRITE: supported = eeprom_enabled;
            RTC_STATUS, RTC_READ, RTC_WRITE: supported = 1'b1;
            default: supported = 1'b0;
        endcase
        data_valid = rx_event.byte_valid && (rx_state == RX_DATA);
    end

    // The reply's own stop bit brings IGNORE back to IDLE
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_state <= RX_IDLE;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    if (rx_event.byte_valid) begin
                        cmd <= cmd_e'(rx_event.byte_data);
                        byte_count <= 4'd0;
                        rx_state <= supported ? RX_DATA : RX_IGNORE;
                    end
                end
                RX_DATA: begin
                    if (data_valid) begin
                        byte_count <= byte_count + 4'd1;
                    end
                    if (rx_event.stop) begin
                        tx_start <= 1'b1;
                        rx_state <= RX_IGNORE;
                    end
                end
                RX_IGNORE: begin
                    if (rx_event.stop) begin
                        rx_state <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
            if (rx_event.timeout) begin
                rx_state <= RX_IDLE;
            end
        end
    end

    // First data byte is the block address
    always_ff @(posedge clk) begin
        if (data_valid && (byte_count == 4'd0)) begin
            block <= rx_event.byte_data;
            subaddr <= '0;
        end else if (data_valid || byte_taken) begin
            subaddr <= subaddr + 1'b1;
        end
    end

    always_comb begin
        eeprom_wr.write = data_valid && (cmd == EEPROM_WRITE) && (byte_count != 4'd0);
        eeprom_wr.address = {block, subaddr};
        eeprom_wr.wdata = rx_event.byte_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rtc.time_wp <= 1'b1;
            rtc.backup_wp <= 1'b1;
            rtc.stopped <= 1'b0;
        end else if (data_valid && (cmd == RTC_WRITE)) begin
            if (block[1:0] == 2'd0) begin
                case (byte_count)
                    4'd1: {rtc.time_wp, rtc.backup_wp} <= rx_event.byte_data[1:0];
                    4'd2: rtc.stopped <= rx_event.byte_data[2];
                    default: ;
                endcase
            end
            // Time fields are locked while time_wp is set
            if ((block[1:0] == 2'd2) && !rtc.time_wp) begin
                case (byte_count)
                    4'd1: rtc.second <= rx_event.byte_data[6:0];
                    4'd2: rtc.minute <= rx_event.byte_data[6:0];
                    4'd3: rtc.hour <= rx_event.byte_data[5:0];
                    4'd4: rtc.day <= rx_event.byte_data[5:0];
                    4'd5: rtc.weekday <= rx_event.byte_data[2:0];
                    4'd6: rtc.month <= rx_event.byte_data[4:0];
                    4'd7: rtc.year <= rx_event.byte_data;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        ctx.cmd = cmd;
        ctx.block = block;
        ctx.rtc = rtc;
        ctx.subaddr = subaddr;
    end

    a_rx_state_legal: assert property (@(posedge clk) disable iff (reset)
        rx_state inside {RX_IDLE, RX_DATA, RX_IGNORE});

endmodule

//--- design/joybus_defines.svh
`ifndef JOYBUS_DEFINES_SVH
`define JOYBUS_DEFINES_SVH

// EEPROM byte address, split into block and subaddress
`define JOYBUS_EEPROM_ADDR_W 11
`define JOYBUS_SUBADDR_W 3

// Low slots out of 8 per transmitted bit
`define JOYBUS_ONE_LOW_SLOTS 2
`define JOYBUS_ZERO_LOW_SLOTS 6

// Receive timing, in serial clocks
`define JOYBUS_RX_ZERO_THRESHOLD 3
`define JOYBUS_RX_STOP_COUNT 7

`endif

//--- design/joybus_device.sv
`include "joybus_defines.svh"

module joybus_device (
    input  logic clk,
    input  logic reset,
    input  logic si_reset,
    input  logic si_clk,
    input  logic si_dq_in,
    input  logic eeprom_enabled,
    input  logic eeprom_16k_mode,
    output logic si_dq_drive_low
);

    import joybus_pkg::*;

    rx_event_t                        rx_event;
    logic                             tx_tick;
    logic                             tx_start;
    cmd_ctx_t                         ctx;
    eeprom_wr_t                       eeprom_wr;
    logic                             byte_taken;
    logic [`JOYBUS_EEPROM_ADDR_W-1:0] eeprom_raddr;
    logic [7:0]                       eeprom_rdata;
    tx_req_t                          tx_req;
    logic                             tx_busy;

    joybus_line_rx i_joybus_line_rx (
        .clk      (clk),
        .reset    (reset),
        .si_reset (si_reset),
        .si_clk   (si_clk),
        .si_dq_in (si_dq_in),
        .rx_event (rx_event),
        .tx_tick  (tx_tick)
    );

    joybus_cmd i_joybus_cmd (
        .clk            (clk),
        .reset          (reset),
        .rx_event       (rx_event),
        .eeprom_enabled (eeprom_enabled),
        .byte_taken     (byte_taken),
        .tx_start       (tx_start),
        .ctx            (ctx),
        .eeprom_wr      (eeprom_wr)
    );

    joybus_reply i_joybus_reply (
        .clk             (clk),
        .reset           (reset),
        .tx_start        (tx_start),
        .ctx             (ctx),
        .eeprom_16k_mode (eeprom_16k_mode),
        .eeprom_rdata    (eeprom_rdata),
        .tx_busy         (tx_busy),
        .eeprom_raddr    (eeprom_raddr),
        .byte_taken      (byte_taken),
        .tx_req          (tx_req)
    );

    joybus_line_tx i_joybus_line_tx (
        .clk             (clk),
        .reset           (reset),
        .tx_tick         (tx_tick),
        .tx_req          (tx_req),
        .tx_busy         (tx_busy),
        .si_dq_drive_low (si_dq_drive_low)
    );

    eeprom_store i_eeprom_store (
        .clk       (clk),
        .eeprom_wr (eeprom_wr),
        .raddr     (eeprom_raddr),
        .rdata     (eeprom_rdata)
    );

endmodule

//--- design/joybus_line_rx.sv
`include "joybus_defines.svh"

module joybus_line_rx (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  si_reset,
    input  logic                  si_clk,
    input  logic                  si_dq_in,
    output joybus_pkg::rx_event_t rx_event,
    output logic                  tx_tick
);

    logic [1:0] si_reset_ff;
    logic [1:0] si_clk_ff;
    logic       dq_in;
    logic       last_si_clk;
    logic       last_dq;
    logic       clk_rise;
    logic       clk_fall;
    logic       dq_fall;
    logic       dq_rise;
    logic [3:0] low_count;
    logic [2:0] bit_count;
    logic [7:0] shift;
    logic       byte_valid;
    logic       stop;
    logic       timeout;

    always_ff @(posedge clk) begin
        si_reset_ff <= {si_reset_ff[0], si_reset};
        si_clk_ff <= {si_clk_ff[0], si_clk};
        last_si_clk <= si_clk_ff[1];
        dq_in <= si_dq_in;
    end

    // Serial edges count only while the console is out of reset
    always_comb begin
        clk_rise = si_reset_ff[1] && !last_si_clk && si_clk_ff[1];
        clk_fall = si_reset_ff[1] && last_si_clk && !si_clk_ff[1];
        dq_fall = clk_rise && last_dq && !dq_in;
        dq_rise = clk_rise && !last_dq && dq_in;
        timeout = clk_rise && dq_in && (&low_count);
        stop = clk_rise && dq_in && (bit_count == 3'd1)
            && (low_count == 4'(`JOYBUS_RX_STOP_COUNT));
    end

    // Counts serial clocks since the last falling data edge
    always_ff @(posedge clk) begin
        if (reset) begin
            last_dq <= 1'b1;
            low_count <= '1;
        end else begin
            if (clk_rise) begin
                last_dq <= dq_in;
            end
            if (dq_fall) begin
                low_count <= 4'd0;
            end else if (clk_rise && !(&low_count)) begin
                low_count <= low_count + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= 3'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= dq_rise && (&bit_count);
            if (dq_rise) begin
                bit_count <= bit_count + 3'd1;
            end else if (timeout) begin
                bit_count <= 3'd0;
            end
        end
    end

    // Long low time decodes as a zero
    always_ff @(posedge clk) begin
        if (dq_rise) begin
            shift <= {shift[6:0], low_count < 4'(`JOYBUS_RX_ZERO_THRESHOLD)};
        end
    end

    always_comb begin
        rx_event.byte_valid = byte_valid;
        rx_event.byte_data = shift;
        rx_event.stop = stop;
        rx_event.timeout = timeout;
        tx_tick = clk_fall;
    end

    a_byte_not_timeout: assert property (@(posedge clk) disable iff (reset)
        !(rx_event.byte_valid && rx_event.timeout));

endmodule

//--- design/joybus_line_tx.sv
`include "joybus_defines.svh"

module joybus_line_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                tx_tick,
    input  joybus_pkg::tx_req_t tx_req,
    output logic                tx_busy,
    output logic                si_dq_drive_low
);

    logic [2:0] slot;
    logic [2:0] bit_count;
    logic [7:0] shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            si_dq_drive_low <= 1'b0;
        end else if (tx_busy) begin
            if (tx_tick) begin
                slot <= slot + 3'd1;
                if (&slot) begin
                    bit_count <= bit_count + 3'd1;
                    shift <= {shift[6:0], 1'b1};
                    if (&bit_count) begin
                        tx_busy <= 1'b0;
                    end
                end
                // MSB first, low phase length gives the bit value
                if (shift[7]) begin
                    si_dq_drive_low <= slot < 3'(`JOYBUS_ONE_LOW_SLOTS);
                end else begin
                    si_dq_drive_low <= slot < 3'(`JOYBUS_ZERO_LOW_SLOTS);
                end
            end
        end else if (tx_req.byte_valid) begin
            tx_busy <= 1'b1;
            slot <= 3'd0;
            bit_count <= 3'd0;
            shift <= tx_req.byte_data;
        end else if (tx_req.stop) begin
            // Stop is a single one bit
            tx_busy <= 1'b1;
            slot <= 3'd0;
            bit_count <= 3'd7;
            shift <= 8'hFF;
        end
    end

    a_req_held_while_busy: assert property (@(posedge clk) disable iff (reset)
        (tx_busy && (tx_req.byte_valid || tx_req.stop)) |=> (tx_req.byte_valid || tx_req.stop));

endmodule

//--- design/joybus_pkg.sv
`include "joybus_defines.svh"

package joybus_pkg;

    typedef enum logic [7:0] {
        EEPROM_STATUS = 8'h00,
        EEPROM_READ   = 8'h04,
        EEPROM_WRITE  = 8'h05,
        RTC_STATUS    = 8'h06,
        RTC_READ      = 8'h07,
        RTC_WRITE     = 8'h08
    } cmd_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_IGNORE
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef struct packed {
        logic       byte_valid;
        logic [7:0] byte_data;
        logic       stop;
        logic       timeout;
    } rx_event_t;

    typedef struct packed {
        logic       byte_valid;
        logic [7:0] byte_data;
        logic       stop;
    } tx_req_t;

    typedef struct packed {
        logic                             write;
        logic [`JOYBUS_EEPROM_ADDR_W-1:0] address;
        logic [7:0]                       wdata;
    } eeprom_wr_t;

    typedef struct packed {
        logic       time_wp;
        logic       backup_wp;
        logic       stopped;
        logic [6:0] second;
        logic [6:0] minute;
        logic [5:0] hour;
        logic [5:0] day;
        logic [2:0] weekday;
        logic [4:0] month;
        logic [7:0] year;
    } rtc_regs_t;

    typedef struct packed {
        cmd_e                                               cmd;
        logic [`JOYBUS_EEPROM_ADDR_W-`JOYBUS_SUBADDR_W-1:0] block;
        rtc_regs_t                                          rtc;
        logic [`JOYBUS_SUBADDR_W-1:0]                       subaddr;
    } cmd_ctx_t;

endpackage

//--- design/joybus_reply.sv
`include "joybus_defines.svh"

module joybus_reply (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             tx_start,
    input  joybus_pkg::cmd_ctx_t             ctx,
    input  logic                             eeprom_16k_mode,
    input  logic [7:0]                       eeprom_rdata,
    input  logic                             tx_busy,
    output logic [`JOYBUS_EEPROM_ADDR_W-1:0] eeprom_raddr,
    output logic                             byte_taken,
    output joybus_pkg::tx_req_t              tx_req
);

    import joybus_pkg::*;

    tx_state_e  tx_state;
    logic [3:0] byte_count;
    logic [3:0] length;
    logic [7:0] byte_data;
    logic [7:0] rtc_status;
    logic       req_valid;
    logic       req_stop;

    always_comb begin
        byte_taken = req_valid && !tx_busy;
        eeprom_raddr = {ctx.block, ctx.subaddr};
        rtc_status = {ctx.rtc.stopped, 7'd0};
        tx_req.byte_valid = req_valid;
        tx_req.byte_data = byte_data;
        tx_req.stop = req_stop;
    end

    // Requests stay up until a cycle with the encoder idle
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_state <= TX_IDLE;
            req_valid <= 1'b0;
            req_stop <= 1'b0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (tx_start) begin
                        byte_count <= 4'd0;
                        req_valid <= 1'b1;
                        tx_state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (byte_taken) begin
                        byte_count <= byte_count + 4'd1;
                        if (byte_count == length) begin
                            req_valid <= 1'b0;
                            req_stop <= 1'b1;
                            tx_state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (!tx_busy) begin
                        req_stop <= 1'b0;
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Length is the index of the last reply byte
    always_comb begin
        length = 4'd0;
        byte_data = 8'h00;
        case (ctx.cmd)
            EEPROM_STATUS: begin
                length = 4'd2;
                if (byte_count == 4'd1) begin
                    byte_data = {1'b1, eeprom_16k_mode, 6'd0};
                end
            end
            EEPROM_READ: begin
                length = 4'd7;
                byte_data = eeprom_rdata;
            end
            RTC_STATUS: begin
                length = 4'd2;
                case (byte_count)
                    4'd1: byte_data = 8'h10;
                    4'd2: byte_data = rtc_status;
                    default: ;
                endcase
            end
            RTC_READ: begin
                length = 4'd8;
                if (ctx.block[1:0] == 2'd0) begin
                    case (byte_count)
                        4'd0: byte_data = {6'd0, ctx.rtc.time_wp, ctx.rtc.backup_wp};
                        4'd1: byte_data = {5'd0, ctx.rtc.stopped, 2'd0};
                        4'd8: byte_data = rtc_status;
                        default: ;
                    endcase
                end else if (ctx.block[1:0] == 2'd2) begin
                    case (byte_count)
                        4'd0: byte_data = {1'b0, ctx.rtc.second};
                        4'd1: byte_data = {1'b0, ctx.rtc.minute};
                        4'd2: byte_data = {2'b10, ctx.rtc.hour};
                        4'd3: byte_data = {2'd0, ctx.rtc.day};
                        4'd4: byte_data = {5'd0, ctx.rtc.weekday};
                        4'd5: byte_data = {3'd0, ctx.rtc.month};
                        4'd6: byte_data = ctx.rtc.year;
                        4'd7: byte_data = 8'h01;
                        4'd8: byte_data = rtc_status;
                        default: ;
                    endcase
                end
            end
            RTC_WRITE: byte_data = rtc_status;
            default: ;
        endcase
    end

    a_count_in_range: assert property (@(posedge clk) disable iff (reset)
        (tx_state == TX_DATA) |-> (byte_count <= length));

endmodule

//--- flist.f
+incdir+design
design/joybus_pkg.sv
design/joybus_line_rx.sv
design/joybus_cmd.sv
design/joybus_reply.sv
design/joybus_line_tx.sv
design/eeprom_store.sv
design/joybus_device.sv
tests/joybus_device_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the Joybus device testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module joybus_device_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vjoybus_device_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- tests/joybus_device_tb.sv
`include "joybus_defines.svh"

module joybus_device_tb;

    import joybus_pkg::*;

    localparam int NUM_ROWS = 18;
    localparam int MAX_BYTES = 12;
    localparam int SILENT_PERIODS = 40;
    localparam int IDLE_PERIODS = 24;
    // Longest frame (10 bytes) and longest reply (9 bytes), each with a stop bit
    localparam int ROW_PERIODS = (8 * 10 + 1 + 8 * 9 + 1) * 8 + SILENT_PERIODS + IDLE_PERIODS + 16;
    localparam int WATCHDOG_TIME = (NUM_ROWS * ROW_PERIODS + 40) * 8 * 40;

    typedef struct packed {
        logic [MAX_BYTES-1:0][7:0] cmd_bytes;
        logic [3:0]                cmd_count;
        logic                      eeprom_enabled;
        logic                      eeprom_16k_mode;
        logic [MAX_BYTES-1:0][7:0] reply_bytes;
        logic [3:0]                reply_count;
    } row_t;

    logic       clk;
    logic       reset;
    logic       si_reset;
    logic       si_clk;
    logic       si_dq_in;
    logic       host_low;
    logic       eeprom_enabled;
    logic       eeprom_16k_mode;
    logic       si_dq_drive_low;

    row_t       rows [0:NUM_ROWS-1];
    row_t       row;
    int         row_total;
    int         current_row;
    int         seed;
    int         error_count;
    logic [7:0] reply [0:15];
    logic [3:0] reply_count;
    logic       reply_seen;
    logic       line_sample;

    // Open-drain line, low when either side pulls it
    assign si_dq_in = !host_low && !si_dq_drive_low;

    joybus_device i_joybus_device (
        .clk             (clk),
        .reset           (reset),
        .si_reset        (si_reset),
        .si_clk          (si_clk),
        .si_dq_in        (si_dq_in),
        .eeprom_enabled  (eeprom_enabled),
        .eeprom_16k_mode (eeprom_16k_mode),
        .si_dq_drive_low (si_dq_drive_low)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        error_count = error_count + 1;
        $display("%s (row %0d)", msg, current_row);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input int index, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] reply_byte[%0d] got %h expected %h",
                                     index, actual, expected));
        end
    endtask

    task automatic check_length(input logic [3:0] actual, input logic [3:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] reply_length got %h expected %h",
                                     actual, expected));
        end
    endtask

    task automatic check_silent(input logic seen);
        if (seen) begin
            report_failure("device drove the line during an ignored command");
        end
    endtask

    task automatic begin_row(input logic enabled, input logic mode_16k);
        row = '0;
        row.eeprom_enabled = enabled;
        row.eeprom_16k_mode = mode_16k;
    endtask

    task automatic add_cmd(input logic [7:0] value);
        row.cmd_bytes[row.cmd_count] = value;
        row.cmd_count = row.cmd_count + 4'd1;
    endtask

    task automatic add_reply(input logic [7:0] value);
        row.reply_bytes[row.reply_count] = value;
        row.reply_count = row.reply_count + 4'd1;
    endtask

    task automatic add_reply_triple(input logic [7:0] a, input logic [7:0] b,
                                    input logic [7:0] c);
        add_reply(a);
        add_reply(b);
        add_reply(c);
    endtask

    task automatic add_block_read(input logic [7:0] cmd, input logic [7:0] block);
        add_cmd(cmd);
        add_cmd(block);
    endtask

    task automatic add_block_write(input logic [7:0] cmd, input logic [7:0] block,
                                   input logic [63:0] data);
        add_block_read(cmd, block);
        for (int i = 0; i < 8; i++) begin
            add_cmd(data[63 - 8 * i -: 8]);
        end
    endtask

    task automatic add_reply_bytes(input logic [63:0] data);
        for (int i = 0; i < 8; i++) begin
            add_reply(data[63 - 8 * i -: 8]);
        end
    endtask

    // Block 2 read: fields at their widths, hour tagged 10, then 01 and status
    task automatic add_time_reply(input logic [63:0] fields, input logic stopped);
        add_reply(fields[63:56] & 8'h7F);
        add_reply(fields[55:48] & 8'h7F);
        add_reply(8'h80 | (fields[47:40] & 8'h3F));
        add_reply(fields[39:32] & 8'h3F);
        add_reply(fields[31:24] & 8'h07);
        add_reply(fields[23:16] & 8'h1F);
        add_reply(fields[15:8]);
        add_reply(8'h01);
        add_reply({stopped, 7'd0});
    endtask

    task automatic store_row;
        rows[row_total] = row;
        row_total = row_total + 1;
    endtask

    task automatic build_table;
        logic [63:0] ee_data;
        logic [63:0] ee_other;
        logic [63:0] time_a;
        logic [63:0] time_b;
        logic [63:0] time_c;
        ee_data = {32'($random(seed)), 32'($random(seed))};
        ee_other = {32'($random(seed)), 32'($random(seed))};
        // second, minute, hour, day, weekday, month, year, pad
        time_a = 64'h4530_2315_0312_9900;
        time_b = 64'h0102_0304_0506_0700;
        time_c = 64'h1122_0501_0609_4200;
        row_total = 0;
        begin_row(1'b1, 1'b0);
        add_cmd(EEPROM_STATUS);
        add_reply_triple(8'h00, 8'h80, 8'h00);
        store_row;
        begin_row(1'b1, 1'b1);
        add_cmd(EEPROM_STATUS);
        add_reply_triple(8'h00, 8'hC0, 8'h00);
        store_row;
        begin_row(1'b1, 1'b0);
        add_cmd(RTC_STATUS);
        add_reply_triple(8'h00, 8'h10, 8'h00);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_write(EEPROM_WRITE, 8'h12, ee_data);
        add_reply(8'h00);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_read(EEPROM_READ, 8'h12);
        add_reply_bytes(ee_data);
        store_row;
        // Disabled EEPROM, then an unknown opcode
        begin_row(1'b0, 1'b0);
        add_block_write(EEPROM_WRITE, 8'h12, ee_other);
        store_row;
        begin_row(1'b0, 1'b0);
        add_block_read(EEPROM_READ, 8'h12);
        store_row;
        begin_row(1'b0, 1'b0);
        add_cmd(EEPROM_STATUS);
        store_row;
        begin_row(1'b1, 1'b0);
        add_cmd(8'h33);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_read(EEPROM_READ, 8'h12);
        add_reply_bytes(ee_data);
        store_row;
        // Time fields are locked out of reset
        begin_row(1'b1, 1'b0);
        add_block_write(RTC_WRITE, 8'h02, time_b);
        add_reply(8'h00);
        store_row;
        // Clear both protect bits and set stopped
        begin_row(1'b1, 1'b0);
        add_block_write(RTC_WRITE, 8'h00, 64'h0004_0000_0000_0000);
        add_reply(8'h80);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_write(RTC_WRITE, 8'h02, time_a);
        add_reply(8'h80);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_read(RTC_READ, 8'h02);
        add_time_reply(time_a, 1'b1);
        store_row;
        // Lock again, the next time write must not land
        begin_row(1'b1, 1'b0);
        add_block_write(RTC_WRITE, 8'h00, 64'h0304_0000_0000_0000);
        add_reply(8'h80);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_write(RTC_WRITE, 8'h02, time_c);
        add_reply(8'h80);
        store_row;
        begin_row(1'b1, 1'b0);
        add_block_read(RTC_READ, 8'h02);
        add_time_reply(time_a, 1'b1);
        store_row;
        begin_row(1'b1, 1'b0);
        add_cmd(RTC_STATUS);
        add_reply_triple(8'h00, 8'h10, 8'h80);
        store_row;
    endtask

    // One serial clock period, console data changes with the falling edge
    task automatic serial_period(input logic drive_low);
        si_clk = 1'b0;
        host_low = drive_low;
        repeat (4) @(negedge clk);
        line_sample = si_dq_in;
        si_clk = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic send_bit(input logic value);
        int low_slots;
        low_slots = value ? `JOYBUS_ONE_LOW_SLOTS : `JOYBUS_ZERO_LOW_SLOTS;
        for (int slot = 0; slot < 8; slot++) begin
            serial_period(slot < low_slots);
        end
    endtask

    task automatic send_frame(input row_t r);
        for (int i = 0; i < int'(r.cmd_count); i++) begin
            for (int b = 7; b >= 0; b--) begin
                send_bit(r.cmd_bytes[i][b]);
            end
        end
        send_bit(1'b1);
    endtask

    // Bits end when the line stays high longer than one bit time
    task automatic receive_reply(output logic seen);
        int         wait_count;
        int         low_time;
        int         high_time;
        int         bit_count;
        logic [7:0] shift;
        logic       done;
        seen = 1'b0;
        reply_count = 4'd0;
        bit_count = 0;
        shift = 8'h00;
        done = 1'b0;
        wait_count = 0;
        serial_period(1'b0);
        while (line_sample && wait_count < SILENT_PERIODS) begin
            serial_period(1'b0);
            wait_count = wait_count + 1;
        end
        if (!line_sample) begin
            seen = 1'b1;
            while (!done) begin
                low_time = 0;
                while (!line_sample) begin
                    if (low_time > 15) begin
                        report_failure("line held low for more than 16 serial clocks");
                    end
                    low_time = low_time + 1;
                    serial_period(1'b0);
                end
                shift = {shift[6:0], low_time < `JOYBUS_RX_ZERO_THRESHOLD};
                bit_count = bit_count + 1;
                if (bit_count % 8 == 0) begin
                    if (reply_count == 4'd15) begin
                        report_failure("reply longer than 15 bytes");
                    end
                    reply[reply_count] = shift;
                    reply_count = reply_count + 4'd1;
                end
                high_time = 0;
                while (line_sample && high_time < 12) begin
                    high_time = high_time + 1;
                    serial_period(1'b0);
                end
                done = line_sample;
            end
            if (bit_count % 8 != 1 || !shift[0]) begin
                report_failure("reply did not end with a single stop bit");
            end
        end
    endtask

    initial begin
        seed = 4;
        error_count = 0;
        current_row = -1;
        reset = 1'b1;
        si_reset = 1'b0;
        si_clk = 1'b0;
        host_low = 1'b0;
        eeprom_enabled = 1'b0;
        eeprom_16k_mode = 1'b0;
        line_sample = 1'b1;
        build_table;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        si_reset = 1'b1;
        repeat (20) serial_period(1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            current_row = i;
            eeprom_enabled = rows[i].eeprom_enabled;
            eeprom_16k_mode = rows[i].eeprom_16k_mode;
            send_frame(rows[i]);
            receive_reply(reply_seen);
            if (rows[i].reply_count == 4'd0) begin
                check_silent(reply_seen);
            end else begin
                check_length(reply_count, rows[i].reply_count);
                for (int b = 0; b < int'(rows[i].reply_count); b++) begin
                    check_byte(b, reply[b], rows[i].reply_bytes[b]);
                end
            end
            repeat (IDLE_PERIODS) serial_period(1'b0);
        end
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before all rows finished");
        $display("Result: FAILED");
        $fatal(1);
    end

endmodule
